// ==== Makefile ====
# Verilator build and run for the pow5_unit testbench.
VERILATOR   ?= verilator
TOP         ?= pow5_unit_tb
FILELIST    ?= pow5_unit.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary -j 0
PASS_STRING ?= TEST PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_STRING)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/pow5_dispatch.sv ====
`timescale 1ns/1ps

module pow5_dispatch (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              n_vld,
    input  pow5_pkg::engine_e mode,
    input  pow5_pkg::data_t   n,
    input  logic              busy_single,
    input  logic              busy_seq,
    output logic              start_single,
    output logic              start_seq,
    output logic              start_pipe,
    output pow5_pkg::data_t   operand,
    output logic              drop
);

    import pow5_pkg::*;

    logic    req_q;                             // request captured on the edge that saw n_vld.
    engine_e mode_q;                            // engine named by that request.
    data_t   n_q;                               // operand of that request.
    logic    drop_d;                            // decode found no free engine.

    // the request is registered first, like the input stage of the single-cycle engine.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q  <= 1'b0;
            mode_q <= ENG_NONE;
        end else begin
            req_q  <= n_vld;
            mode_q <= mode;
        end
    end

    always_ff @(posedge clk) begin
        if (n_vld) n_q <= n;                    // payload only follows a valid request.
    end

    // busy is sampled one cycle after the request, so a busy engine rejects it here.
    always_comb begin
        start_single = 1'b0;
        start_seq    = 1'b0;
        start_pipe   = 1'b0;
        drop_d       = 1'b0;
        if (req_q) begin
            case (mode_q)
                ENG_SINGLE: begin
                    start_single = !busy_single; // only a free engine gets the strobe.
                    drop_d       = busy_single;
                end
                ENG_SEQ: begin
                    start_seq = !busy_seq;
                    drop_d    = busy_seq;
                end
                ENG_PIPE: start_pipe = 1'b1;    // the pipe accepts every cycle.
                default:  drop_d     = 1'b1;    // ENG_NONE always goes away.
            endcase
        end
    end

    assign operand = n_q;                       // one operand bus feeds all engines.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) drop <= 1'b0;
        else         drop <= drop_d;            // pulse appears after edge 1.
    end

endmodule

// ==== logic/pow5_pipe.sv ====
`timescale 1ns/1ps

module pow5_pipe (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  pow5_pkg::data_t   operand,
    pow5_res_if.engine        res
);

    import pow5_pkg::*;

    logic [PIPE_DEPTH - 1:0] vld_q;             // one valid bit per stage, bit 0 is the first stage.
    data_t                   pow_q [PIPE_DEPTH];     // n**(i+2) in stage i.
    data_t                   n_q   [PIPE_DEPTH - 1]; // operand delayed along with its power.

    // valid bits move one stage per cycle and never stall.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[PIPE_DEPTH - 2:0], start};
        end
    end

    // the first stage squares the operand, every later stage multiplies by its own copy.
    always_ff @(posedge clk) begin
        pow_q[0] <= operand * operand;
        n_q[0]   <= operand;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            pow_q[i] <= pow_q[i - 1] * n_q[i - 1];
        end
        for (int i = 1; i < PIPE_DEPTH - 1; i++) begin
            n_q[i] <= n_q[i - 1];               // the last stage needs the copy from stage 2.
        end
    end

    // top priority means the grant always comes in this same cycle, so req is a single pulse.
    assign res.req  = vld_q[PIPE_DEPTH - 1];
    assign res.data = pow_q[PIPE_DEPTH - 1];    // n**5 after the last stage.

endmodule

// ==== logic/pow5_pkg.sv ====
package pow5_pkg;

    localparam int DATA_W = 8;                  // operand and result width in bits.

    typedef logic [DATA_W - 1:0] data_t;        // all arithmetic wraps modulo 2**DATA_W.

    // engine select code on the mode input and tag on res_eng.
    typedef enum logic [1:0] {
        ENG_SINGLE = 2'd0,                      // registered single-cycle engine.
        ENG_SEQ    = 2'd1,                      // multiply loop engine.
        ENG_PIPE   = 2'd2,                      // four-stage pipeline engine.
        ENG_NONE   = 2'd3                       // no engine here, request is dropped.
    } engine_e;

    localparam int SEQ_STEPS  = 4;              // multiplies after the first load, n -> n**5.
    localparam int PIPE_DEPTH = 4;              // pipeline stages between start and req.

endpackage

// ==== logic/pow5_res_arb.sv ====
`timescale 1ns/1ps

module pow5_res_arb (
    input  logic              clk,
    input  logic              arst_n,
    pow5_res_if.arbiter       pipe_res,
    pow5_res_if.arbiter       single_res,
    pow5_res_if.arbiter       seq_res,
    output logic              res_vld,
    output pow5_pkg::data_t   res,
    output pow5_pkg::engine_e res_eng
);

    import pow5_pkg::*;

    logic    any_req;                           // some engine is offering a result.
    data_t   sel_data;                          // value of the winner.
    engine_e sel_eng;                           // tag of the winner.

    // fixed priority: the pipe cannot wait, then single, then seq.
    assign pipe_res.grant   = pipe_res.req;
    assign single_res.grant = single_res.req & !pipe_res.req;
    assign seq_res.grant    = seq_res.req & !pipe_res.req & !single_res.req;

    assign any_req = pipe_res.req | single_res.req | seq_res.req;

    always_comb begin
        if (pipe_res.req) begin
            sel_data = pipe_res.data;
            sel_eng  = ENG_PIPE;
        end else if (single_res.req) begin
            sel_data = single_res.data;
            sel_eng  = ENG_SINGLE;
        end else begin
            sel_data = seq_res.data;            // also the idle default, res_vld stays low then.
            sel_eng  = ENG_SEQ;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) res_vld <= 1'b0;
        else         res_vld <= any_req;        // one beat per grant.
    end

    always_ff @(posedge clk) begin
        if (any_req) begin
            res     <= sel_data;
            res_eng <= sel_eng;                 // the tag travels with its value.
        end
    end

endmodule

// ==== logic/pow5_res_if.sv ====
`timescale 1ns/1ps

interface pow5_res_if;

    import pow5_pkg::*;

    logic  req;                                 // result waiting, a level until granted.
    data_t data;                                // result value, stable while req is high.
    logic  grant;                               // one-cycle pulse from the arbiter.

    // engine side offers a result and watches for its grant.
    modport engine (
        output req,
        output data,
        input  grant
    );

    // arbiter side picks one offer per cycle.
    modport arbiter (
        input  req,
        input  data,
        output grant
    );

endinterface

// ==== logic/pow5_seq.sv ====
`timescale 1ns/1ps

module pow5_seq (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  pow5_pkg::data_t   operand,
    output logic              busy,
    pow5_res_if.engine        res
);

    import pow5_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,                               // waiting for a start strobe.
        SEQ_MUL,                                // one multiply per cycle.
        SEQ_HOLD                                // result offered until granted.
    } seq_state_e;

    seq_state_e                       state_q;
    logic [$clog2(SEQ_STEPS) - 1:0]   step_q;   // counts the multiplies already done.
    logic                             load;     // start accepted in idle.
    data_t                            op_q;     // operand kept for every step.
    data_t                            acc_q;    // running power, starts at n.

    assign load = start & (state_q == SEQ_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= SEQ_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (load) state_q <= SEQ_MUL;
                    step_q <= '0;               // every run counts from zero.
                end
                SEQ_MUL: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == SEQ_STEPS - 1) state_q <= SEQ_HOLD; // n**5 after the last step.
                end
                SEQ_HOLD: begin
                    if (res.grant) state_q <= SEQ_IDLE; // leaves on the edge after grant.
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // accumulator and operand copy, as in the shift-register loop of the sequential variant.
    always_ff @(posedge clk) begin
        if (load) begin
            op_q  <= operand;
            acc_q <= operand;
        end else if (state_q == SEQ_MUL) begin
            acc_q <= acc_q * op_q;
        end
    end

    assign busy     = (state_q != SEQ_IDLE);    // covers multiply and hold.
    assign res.req  = (state_q == SEQ_HOLD);
    assign res.data = acc_q;                    // frozen once the loop ends.

endmodule

// ==== logic/pow5_single.sv ====
`timescale 1ns/1ps

module pow5_single (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  pow5_pkg::data_t   operand,
    output logic              busy,
    pow5_res_if.engine        res
);

    import pow5_pkg::*;

    logic  accept;                              // start seen while idle.
    logic  calc_q;                              // operand is held and the power is being formed.
    logic  req_q;                               // result is held and offered to the arbiter.
    data_t op_q;                                // registered operand.
    data_t res_q;                               // registered fifth power.

    assign busy   = calc_q | req_q;             // high from acceptance until the grant edge.
    assign accept = start & !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            calc_q <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            calc_q <= accept;                   // one cycle in the multiply stage.
            if (calc_q) begin
                req_q <= 1'b1;                  // result ready after edge 2.
            end else if (res.grant) begin
                req_q <= 1'b0;                  // drops in the cycle after the grant.
            end
        end
    end

    // the whole product is one combinational cloud between two registers.
    always_ff @(posedge clk) begin
        if (accept) op_q  <= operand;
        if (calc_q) res_q <= op_q * op_q * op_q * op_q * op_q;
    end

    assign res.req  = req_q;
    assign res.data = res_q;                    // stays put while req is held.

endmodule

// ==== logic/pow5_unit.sv ====
`timescale 1ns/1ps

module pow5_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              n_vld,
    input  pow5_pkg::engine_e mode,
    input  pow5_pkg::data_t   n,
    output logic              res_vld,
    output logic              drop,
    output pow5_pkg::data_t   res,
    output pow5_pkg::engine_e res_eng
);

    import pow5_pkg::*;

    logic  start_single;                        // one-cycle strobes from the dispatcher.
    logic  start_seq;
    logic  start_pipe;
    logic  busy_single;                         // engine levels back to the dispatcher.
    logic  busy_seq;
    data_t operand;                             // shared by all three engines.

    pow5_res_if res_single ();                  // one result channel per engine.
    pow5_res_if res_seq ();
    pow5_res_if res_pipe ();

    pow5_dispatch dispatch_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .n_vld        (n_vld),
        .mode         (mode),
        .n            (n),
        .busy_single  (busy_single),
        .busy_seq     (busy_seq),
        .start_single (start_single),
        .start_seq    (start_seq),
        .start_pipe   (start_pipe),
        .operand      (operand),
        .drop         (drop)
    );

    pow5_single single_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start_single),
        .operand (operand),
        .busy    (busy_single),
        .res     (res_single.engine)
    );

    pow5_seq seq_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start_seq),
        .operand (operand),
        .busy    (busy_seq),
        .res     (res_seq.engine)
    );

    pow5_pipe pipe_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start_pipe),
        .operand (operand),
        .res     (res_pipe.engine)
    );

    pow5_res_arb res_arb_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .pipe_res   (res_pipe.arbiter),
        .single_res (res_single.arbiter),
        .seq_res    (res_seq.arbiter),
        .res_vld    (res_vld),
        .res        (res),
        .res_eng    (res_eng)
    );

endmodule

// ==== pow5_unit.f ====
logic/pow5_pkg.sv
logic/pow5_res_if.sv
logic/pow5_dispatch.sv
logic/pow5_single.sv
logic/pow5_seq.sv
logic/pow5_pipe.sv
logic/pow5_res_arb.sv
logic/pow5_unit.sv
verif/pow5_unit_tb.sv

// ==== verif/pow5_unit_tb.sv ====
`timescale 1ns/1ps

module pow5_unit_tb;

    import pow5_pkg::*;

    logic        clk;
    logic        arst_n;
    logic        n_vld;
    engine_e     mode;
    data_t       n;
    logic        res_vld;
    logic        drop;
    data_t       res;
    engine_e     res_eng;

    logic [31:0] lfsr_state;                    // operand source, stepped once per bit.
    int          cyc;                           // rising edges seen so far.
    int          err_cnt;
    int          check_cnt;
    int          test_err;                      // errors of the test that is running.
    data_t       mon_data [$];                  // res_vld beats in arrival order.
    engine_e     mon_eng [$];
    int          mon_cyc [$];                   // edge after which the beat was high.
    int          drop_cyc [$];                  // edges after which drop was high.
    int          beat_cnt [4];                  // beats seen per engine tag.

    pow5_unit pow5_unit_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .n_vld   (n_vld),
        .mode    (mode),
        .n       (n),
        .res_vld (res_vld),
        .drop    (drop),
        .res     (res),
        .res_eng (res_eng)
    );

    always #50 clk = ~clk;                      // 100 ns period.

    // outputs are registered, so the rising edge still sees the values of the previous edge.
    always @(posedge clk) begin
        if (res_vld) begin
            mon_data.push_back(res);
            mon_eng.push_back(res_eng);
            mon_cyc.push_back(cyc);
            beat_cnt[int'(res_eng)]++;
        end
        if (drop) drop_cyc.push_back(cyc);
        cyc = cyc + 1;
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic data_t rand_data();
        data_t v;
        v = '0;
        for (int i = 0; i < DATA_W; i++) v = {v[DATA_W - 2:0], lfsr_bit()};
        return v;
    endfunction

    // n multiplied into 1 five times, wrapping at 8 bits.
    function automatic data_t pow5_ref(data_t x);
        data_t p;
        p = 8'd1;
        for (int i = 0; i < 5; i++) p = p * x;
        return p;
    endfunction

    task automatic note_failure(string line);
        $display("%s", line);
        err_cnt++;
        test_err++;
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        check_cnt++;
        if (got !== exp) note_failure($sformatf("MISMATCH %s: got 0x%02h, expected 0x%02h",
                                                name, got, exp));
    endtask

    task automatic check_eng(string name, engine_e got, engine_e exp);
        check_cnt++;
        if (got !== exp) note_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                                name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        check_cnt++;
        if (got !== exp) note_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                                name, got, exp));
    endtask

    task automatic end_test(string name);
        if (test_err == 0) $display("%-16s ok", name);
        else               $display("%-16s %0d errors", name, test_err);
        test_err = 0;
    endtask

    task automatic timeout_abort(string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic flush_monitor();
        mon_data.delete();
        mon_eng.delete();
        mon_cyc.delete();
        drop_cyc.delete();
        for (int i = 0; i < 4; i++) beat_cnt[i] = 0;
    endtask

    // called on a falling edge, returns the number of the edge that samples the request.
    task automatic drive_req(input engine_e m, input data_t x, output int req_edge);
        n_vld    = 1'b1;
        mode     = m;
        n        = x;
        req_edge = cyc + 1;
        @(negedge clk);
    endtask

    task automatic drive_idle();
        n_vld = 1'b0;
    endtask

    task automatic idle_cycles(int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic wait_beats(int count, int limit, string what);
        int t;
        t = 0;
        while (mon_data.size() < count && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (mon_data.size() < count) timeout_abort(what);
    endtask

    task automatic wait_drops(int count, int limit, string what);
        int t;
        t = 0;
        while (drop_cyc.size() < count && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (drop_cyc.size() < count) timeout_abort(what);
    endtask

    // an engine is free once every result it was given has left on the bus.
    task automatic wait_free(engine_e e, int issued, int limit);
        int t;
        t = 0;
        while (beat_cnt[int'(e)] < issued && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (beat_cnt[int'(e)] < issued) timeout_abort("a free engine");
    endtask

    task automatic run_basic();
        data_t   ops [21];
        engine_e engs [3];
        int      lat [3];
        int      req_edge;
        check_flag("res_vld after reset", res_vld, 1'b0);
        check_flag("drop after reset", drop, 1'b0);
        ops[0] = 8'd0;
        ops[1] = 8'd1;
        ops[2] = 8'd2;
        ops[3] = 8'd3;
        ops[4] = 8'd255;
        for (int i = 5; i < 21; i++) ops[i] = rand_data();
        engs[0] = ENG_SINGLE;
        engs[1] = ENG_SEQ;
        engs[2] = ENG_PIPE;
        lat[0]  = 3;                            // uncontended edges from request to res_vld.
        lat[1]  = 6;
        lat[2]  = 5;
        for (int e = 0; e < 3; e++) begin
            for (int i = 0; i < 21; i++) begin
                flush_monitor();
                drive_req(engs[e], ops[i], req_edge);
                drive_idle();
                wait_beats(1, 20, "a single result");
                check_data($sformatf("res for n 0x%02h", ops[i]), mon_data[0], pow5_ref(ops[i]));
                check_eng("res_eng", mon_eng[0], engs[e]);
                check_flag($sformatf("res_vld latency for n 0x%02h", ops[i]),
                           mon_cyc[0] == req_edge + lat[e], 1'b1);
            end
        end
        end_test("basic");
    endtask

    task automatic run_pipe_stream();
        data_t ops [8];
        int    req_edge [8];
        flush_monitor();
        for (int i = 0; i < 8; i++) begin
            ops[i] = rand_data();
            drive_req(ENG_PIPE, ops[i], req_edge[i]); // one operand every cycle.
        end
        drive_idle();
        wait_beats(8, 20, "the pipe stream");
        for (int i = 0; i < 8; i++) begin
            check_data($sformatf("pipe res %0d", i), mon_data[i], pow5_ref(ops[i]));
            check_eng("res_eng", mon_eng[i], ENG_PIPE);
            check_flag($sformatf("res_vld 5 cycles after pipe request %0d", i),
                       mon_cyc[i] == req_edge[i] + 5, 1'b1);
        end
        end_test("pipe stream");
    endtask

    task automatic run_drops();
        data_t a;
        data_t b;
        int    e1;
        int    e2;
        a = rand_data();
        b = rand_data();
        flush_monitor();
        drive_req(ENG_SEQ, a, e1);
        drive_req(ENG_SEQ, b, e2);              // arrives while the first run is busy.
        drive_idle();
        wait_beats(1, 20, "the seq result");
        idle_cycles(10);                        // room for a second beat that must not come.
        if (drop_cyc.size() != 1) note_failure($sformatf("drop pulsed %0d times, not once",
                                                         drop_cyc.size()));
        else check_flag("drop one cycle after busy request", drop_cyc[0] == e2 + 1, 1'b1);
        if (mon_data.size() != 1) note_failure($sformatf("%0d results for one accepted request",
                                                         mon_data.size()));
        check_data("seq res", mon_data[0], pow5_ref(a));
        check_eng("res_eng", mon_eng[0], ENG_SEQ);
        flush_monitor();
        drive_req(ENG_NONE, b, e1);
        drive_idle();
        wait_drops(1, 10, "drop on an unmapped mode");
        idle_cycles(10);
        if (drop_cyc.size() != 1) note_failure("unmapped mode did not give exactly one drop");
        else check_flag("drop one cycle after unmapped request", drop_cyc[0] == e1 + 1, 1'b1);
        if (mon_data.size() != 0) note_failure("unmapped mode produced a result");
        end_test("drops");
    endtask

    task automatic run_contention();
        data_t a;
        data_t b;
        int    p;
        int    s;
        a = rand_data();
        b = rand_data();
        flush_monitor();
        drive_req(ENG_PIPE, a, p);
        drive_idle();
        @(negedge clk);
        drive_req(ENG_SINGLE, b, s);            // single req rises with the pipe req.
        drive_idle();
        wait_beats(2, 20, "both contended results");
        check_eng("first res_eng", mon_eng[0], ENG_PIPE);
        check_data("pipe res", mon_data[0], pow5_ref(a));
        check_flag("pipe beat on time", mon_cyc[0] == p + 5, 1'b1);
        check_eng("second res_eng", mon_eng[1], ENG_SINGLE);
        check_data("single res", mon_data[1], pow5_ref(b));
        check_flag("single beat one cycle late", mon_cyc[1] == p + 6, 1'b1);
        end_test("contention");
    endtask

    task automatic run_mixed();
        data_t   exp_single [$];
        data_t   exp_seq [$];
        int      issued [4];
        engine_e e;
        data_t   x;
        int      req_edge;
        flush_monitor();
        for (int i = 0; i < 4; i++) issued[i] = 0;
        for (int i = 0; i < 12; i++) begin
            e = (i % 2 == 0) ? ENG_SINGLE : ENG_SEQ;
            wait_free(e, issued[int'(e)], 30);
            x = rand_data();
            if (e == ENG_SINGLE) exp_single.push_back(pow5_ref(x));
            else                 exp_seq.push_back(pow5_ref(x));
            issued[int'(e)]++;
            drive_req(e, x, req_edge);
            drive_idle();
        end
        wait_beats(12, 100, "the mixed stream");
        idle_cycles(10);
        if (mon_data.size() != 12) note_failure("extra beats in the mixed stream");
        for (int i = 0; i < mon_data.size(); i++) begin
            if (mon_eng[i] == ENG_SINGLE && exp_single.size() > 0)
                check_data("single res", mon_data[i], exp_single.pop_front());
            else if (mon_eng[i] == ENG_SEQ && exp_seq.size() > 0)
                check_data("seq res", mon_data[i], exp_seq.pop_front());
            else
                note_failure($sformatf("beat %0d carries a tag with nothing expected", i));
        end
        if (exp_single.size() + exp_seq.size() != 0) note_failure("results lost in mixed stream");
        end_test("mixed stream");
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        n_vld      = 1'b0;
        mode       = ENG_NONE;
        n          = '0;
        lfsr_state = 32'h7b8d7fcf;
        cyc        = 0;
        err_cnt    = 0;
        check_cnt  = 0;
        test_err   = 0;
        repeat (5) @(negedge clk);              // reset held for five cycles.
        arst_n = 1'b1;
        @(negedge clk);
        run_basic();
        run_pipe_stream();
        run_drops();
        run_contention();
        run_mixed();
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) $display("TEST PASSED");
        else              $display("TEST FAILED");
        $finish;
    end

endmodule
